/* src.f */
common/scratchPkg.sv
sram/sram1p1rw.sv
verilog/apbFront.sv
verilog/laneSteer.sv
verilog/scratchTop.sv
verification/scratchChecker.sv
verification/scratchTb.sv

/* run.sh */
#!/bin/sh
# Build the scratchpad testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module scratchTb -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/VscratchTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi

/* verification/scratchTb.sv */
// APB scratchpad testbench

`timescale 1ns/100ps

module scratchTb;

  import scratchPkg::*;

  localparam int lineCount   = 64;
  localparam int windowBytes = lineCount * LINE_BYTES;
  localparam int wordCount   = lineCount * WORDS_PER_LINE;
  localparam int clkPeriod   = 8;
  localparam int resetCycles = 3;
  localparam int driveDelay  = 1;

  // One stimulus row with the response the plan's rules predict for it
  typedef struct packed {
    logic    write;
    apbAddrT addr;
    apbDataT wdata;
    apbStrbT strb;
    apbDataT expRdata;
    logic    expErr;
  } rowT;

  logic    clk = 1'b0;
  logic    arstN;
  logic    psel;
  logic    penable;
  logic    pwrite;
  apbAddrT paddr;
  apbDataT pwdata;
  apbStrbT pstrb;
  logic    pready;
  apbDataT prdata;
  logic    pslverr;

  // Expected response of the transfer on the bus, handed to the checker
  apbDataT expRdata;
  logic    expErr;

  int      errorCount;
  int      checkCount;
  int      completionCount;
  int      tbErrors;

  rowT     rowTable[$];
  logic    tableReady = 1'b0;

  // Word-wide image of the scratchpad as the write rule leaves it
  apbDataT shadow [wordCount];

  always #(clkPeriod / 2) clk = ~clk;

  scratchTop #(.lineCount(lineCount)) dut_i (
    .clk(clk), .arstN(arstN),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .pready(pready), .prdata(prdata), .pslverr(pslverr)
  );

  scratchChecker checker_i (
    .clk(clk), .arstN(arstN),
    .psel(psel), .penable(penable), .pready(pready),
    .paddr(paddr), .prdata(prdata), .pslverr(pslverr),
    .expRdata(expRdata), .expErr(expErr),
    .errorCount(errorCount), .checkCount(checkCount),
    .completionCount(completionCount)
  );

  //////////////////////////////////////////////////////////////////////
  // Table building
  //////////////////////////////////////////////////////////////////////

  // A write in the window merges the strobed bytes into the old word
  // A write completes with zero read data either way
  task automatic appendWrite(input apbAddrT addr, input apbDataT data, input apbStrbT strb);
    rowT row;
    int  wordIdx;
    row.write    = 1'b1;
    row.addr     = addr;
    row.wdata    = data;
    row.strb     = strb;
    row.expRdata = '0;
    row.expErr   = addr >= apbAddrT'(windowBytes);
    if (!row.expErr) begin
      wordIdx = int'(addr >> 2);
      for (int b = 0; b < APB_STRB_W; b++) begin
        if (strb[b]) begin
          shadow[wordIdx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    rowTable.push_back(row);
  endtask

  // An errored read returns zero
  task automatic expectRead(input apbAddrT addr);
    rowT row;
    row.write    = 1'b0;
    row.addr     = addr;
    row.wdata    = '0;
    row.strb     = '0;
    row.expErr   = addr >= apbAddrT'(windowBytes);
    row.expRdata = row.expErr ? '0 : shadow[int'(addr >> 2)];
    rowTable.push_back(row);
  endtask

  task automatic buildTable();
    int randIdx [6];
    // Neighbors on both sides of line 5
    appendWrite(32'h0000_004C, 32'h4C4C_4C4C, 4'hF);
    appendWrite(32'h0000_0060, 32'h6060_6060, 4'hF);
    // Every word of line 5, then read back with the neighbors
    appendWrite(32'h0000_0050, 32'h1111_0000, 4'hF);
    appendWrite(32'h0000_0054, 32'h2222_1111, 4'hF);
    appendWrite(32'h0000_0058, 32'h3333_2222, 4'hF);
    appendWrite(32'h0000_005C, 32'h4444_3333, 4'hF);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      expectRead(apbAddrT'(32'h50 + 4 * w));
    end
    expectRead(32'h0000_004C);
    expectRead(32'h0000_0060);
    // Partial strobes keep the bytes that are not enabled
    appendWrite(32'h0000_0054, 32'hAABB_CCDD, 4'b0101);
    expectRead(32'h0000_0054);
    appendWrite(32'h0000_0058, 32'h0102_0304, 4'b1000);
    expectRead(32'h0000_0058);
    appendWrite(32'h0000_005C, 32'hF0E1_D2C3, 4'b0110);
    expectRead(32'h0000_005C);
    // First and last lines of the window
    appendWrite(32'h0000_0000, 32'hA5A5_0000, 4'hF);
    appendWrite(32'h0000_03F0, 32'h5A5A_03F0, 4'hF);
    appendWrite(32'h0000_03FC, 32'hC3C3_03FC, 4'hF);
    expectRead(32'h0000_0000);
    expectRead(32'h0000_03F0);
    expectRead(32'h0000_03FC);
    // 0x400 aliases line 0 in the low address bits
    appendWrite(32'h0000_0400, 32'hDEAD_BEEF, 4'hF);
    expectRead(32'h0000_0400);
    expectRead(32'h0000_0000);
    appendWrite(32'h1000_0000, 32'h0BAD_F00D, 4'hF);
    expectRead(32'hFFFF_FFFC);
    // Random words, with expected values taken from the image
    for (int i = 0; i < 6; i++) begin
      randIdx[i] = int'($urandom_range(wordCount - 1));
      appendWrite(apbAddrT'(randIdx[i]) << 2, $urandom(), 4'hF);
    end
    for (int i = 0; i < 6; i++) begin
      expectRead(apbAddrT'(randIdx[i]) << 2);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////////////////////////

  // Called just after a rising edge; returns just after the completion
  // edge, so rows follow each other back to back
  task automatic applyRow(input rowT row);
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = row.write;
    paddr    = row.addr;
    pwdata   = row.wdata;
    pstrb    = row.strb;
    expRdata = row.expRdata;
    expErr   = row.expErr;
    @(posedge clk);
    #driveDelay;
    penable = 1'b1;
    // pready is settled by the falling edge
    do begin
      @(negedge clk);
    end while (!pready);
    @(posedge clk);
    #driveDelay;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int totalErrors;
    void'($urandom(32'hc55e_5ace));
    arstN    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pstrb    = '0;
    expRdata = '0;
    expErr   = 1'b0;
    tbErrors = 0;
    buildTable();
    tableReady = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    arstN = 1'b1;
    foreach (rowTable[i]) begin
      applyRow(rowTable[i]);
    end
    psel    = 1'b0;
    penable = 1'b0;
    repeat (2) @(posedge clk);
    #driveDelay;
    if (completionCount != rowTable.size()) begin
      tbErrors++;
      $display("Only %0d of %0d transfers completed", completionCount, rowTable.size());
    end
    totalErrors = errorCount + tbErrors;
    $display("Transfers: %0d, checks: %0d, errors: %0d", completionCount, checkCount,
             totalErrors);
    if (totalErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Each row needs three clocks, so four per row leaves some slack
  initial begin
    int limitCycles;
    wait (tableReady);
    limitCycles = rowTable.size() * 4 + resetCycles + 4;
    #(limitCycles * clkPeriod);
    $display("Timeout: the run did not end within %0d clocks", limitCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* verification/scratchChecker.sv */
// APB completion checker

`timescale 1ns/100ps

module scratchChecker (
  input  logic                clk,
  input  logic                arstN,
  input  logic                psel,
  input  logic                penable,
  input  logic                pready,
  input  scratchPkg::apbAddrT paddr,
  input  scratchPkg::apbDataT prdata,
  input  logic                pslverr,
  input  scratchPkg::apbDataT expRdata,
  input  logic                expErr,
  output int                  errorCount,
  output int                  checkCount,
  output int                  completionCount
);

  import scratchPkg::*;

  // Clocks seen since reset was released
  int   cycleCount;

  // Clock number of the SETUP edge of the transfer in flight
  int   setupCycle;

  // Set once pready has been looked at right after reset
  logic resetChecked;

  initial begin
    errorCount      = 0;
    checkCount      = 0;
    completionCount = 0;
    cycleCount      = 0;
    setupCycle      = 0;
    resetChecked    = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Sampling at every rising edge
  //////////////////////////////////////////////////////////////////////

  // Inputs change a little after the edge, so the values seen here are
  // the ones the DUT itself samples on this edge
  always @(posedge clk) begin
    if (arstN) begin
      cycleCount++;

      // The first edge out of reset comes before any SETUP has been seen
      if (!resetChecked) begin
        resetChecked = 1'b1;
        checkCount++;
        if (pready !== 1'b0) begin
          errorCount++;
          $display("[ERROR] pready after reset: expected 0x0, got 0x%h", pready);
        end
      end

      if (psel && !penable) begin
        setupCycle = cycleCount;
      end

      // Completion edge of a transfer
      if (psel && penable && pready) begin
        completionCount++;
        checkCount += 3;
        if (prdata !== expRdata) begin
          errorCount++;
          $display("[ERROR] prdata at 0x%h: expected 0x%h, got 0x%h", paddr, expRdata, prdata);
        end
        if (pslverr !== expErr) begin
          errorCount++;
          $display("[ERROR] pslverr at 0x%h: expected 0x%h, got 0x%h", paddr, expErr, pslverr);
        end
        // One wait state puts completion two clocks after SETUP
        if (cycleCount - setupCycle != 2) begin
          errorCount++;
          $display("[ERROR] latency at 0x%h: expected 0x2, got 0x%h", paddr,
                   cycleCount - setupCycle);
        end
      end
    end
  end

endmodule

/* verilog/scratchTop.sv */
// APB scratchpad top level

`timescale 1ns/100ps

module scratchTop #(
  parameter int lineCount = 256
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  scratchPkg::apbAddrT paddr,
  input  scratchPkg::apbDataT pwdata,
  input  scratchPkg::apbStrbT pstrb,
  output logic                pready,
  output scratchPkg::apbDataT prdata,
  output logic                pslverr
);

  import scratchPkg::*;

  localparam int idxWidth = $clog2(lineCount);

  // Front stage to lane stage
  lineReqT             req;
  logic [idxWidth-1:0] lineIdx;
  logic                reqValid;
  apbDataT             rdWord;

  // Lane stage to SRAM
  logic [idxWidth-1:0] sramAdr;
  lineDataT            sramWdata;
  logic                sramWe;
  lineStrbT            sramByteWe;
  lineDataT            sramRdata;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  // APB completer, decodes the window and issues one request per transfer
  apbFront #(.lineCount(lineCount)) front_i (
    .clk(clk), .arstN(arstN),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .pready(pready), .prdata(prdata), .pslverr(pslverr),
    .reqValid(reqValid), .req(req), .lineIdx(lineIdx), .rdWord(rdWord)
  );

  // Word to line conversion and read lane pick
  laneSteer #(.lineCount(lineCount)) steer_i (
    .clk(clk), .arstN(arstN),
    .reqValid(reqValid), .req(req), .lineIdx(lineIdx),
    .sramAdr(sramAdr), .sramWdata(sramWdata), .sramWe(sramWe),
    .sramByteWe(sramByteWe), .sramRdata(sramRdata), .rdWord(rdWord)
  );

  // Line storage
  sram1p1rw #(.lineCount(lineCount)) sram_i (
    .clk(clk), .Adr(sramAdr), .CacheWriteData(sramWdata),
    .WriteEnable(sramWe), .ByteWe(sramByteWe), .ReadData(sramRdata)
  );

endmodule

/* verilog/laneSteer.sv */
// Word-to-line lane steering

`timescale 1ns/100ps

module laneSteer #(
  parameter int lineCount = 256
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         reqValid,
  input  scratchPkg::lineReqT          req,
  input  logic [$clog2(lineCount)-1:0] lineIdx,
  output logic [$clog2(lineCount)-1:0] sramAdr,
  output scratchPkg::lineDataT         sramWdata,
  output logic                         sramWe,
  output scratchPkg::lineStrbT         sramByteWe,
  input  scratchPkg::lineDataT         sramRdata,
  output scratchPkg::apbDataT          rdWord
);

  import scratchPkg::*;

  // Word select of the last request, lined up with the read data
  wordSelT                   rdSelQ;

  // One bit per lane, set when any byte of that lane is enabled
  logic [WORDS_PER_LINE-1:0] laneActive;

  //////////////////////////////////////////////////////////////////////
  // Request path toward the SRAM
  //////////////////////////////////////////////////////////////////////

  // The line index goes straight through
  assign sramAdr = lineIdx;

  // The word is copied to every lane and the byte enables pick the one
  // that really gets written
  assign sramWdata = {WORDS_PER_LINE{req.wdata}};

  // Strobe nibble shifted into the lane chosen by the word select
  assign sramByteWe = lineStrbT'(req.strb) << (req.wordSel * APB_STRB_W);

  // A request without the write bit is a read and leaves the array alone
  assign sramWe = reqValid && req.write;

  //////////////////////////////////////////////////////////////////////
  // Read lane select
  //////////////////////////////////////////////////////////////////////

  // The SRAM answers one cycle after the request edge
  // Holding the word select across that edge keeps the mux aligned
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdSelQ <= '0;
    end else if (reqValid) begin
      rdSelQ <= req.wordSel;
    end
  end

  // Pick the 32-bit lane out of the returned line
  assign rdWord = sramRdata[rdSelQ * APB_DATA_W +: APB_DATA_W];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Collapse each strobe nibble to one bit per lane
  for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : gLane
    assign laneActive[i] = |sramByteWe[i*APB_STRB_W +: APB_STRB_W];
  end

  // A write from the APB side never touches more than one lane
  oneLanePerWrite : assert property (
    @(posedge clk) disable iff (!arstN)
    sramWe |-> $onehot0(laneActive)
  ) else $error("byte enables span more than one lane");

endmodule

/* verilog/apbFront.sv */
// APB completer front stage

`timescale 1ns/100ps

module apbFront #(
  parameter int lineCount = 256
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  scratchPkg::apbAddrT          paddr,
  input  scratchPkg::apbDataT          pwdata,
  input  scratchPkg::apbStrbT          pstrb,
  output logic                         pready,
  output scratchPkg::apbDataT          prdata,
  output logic                         pslverr,
  output logic                         reqValid,
  output scratchPkg::lineReqT          req,
  output logic [$clog2(lineCount)-1:0] lineIdx,
  input  scratchPkg::apbDataT          rdWord
);

  import scratchPkg::*;

  localparam int idxWidth = $clog2(lineCount);

  // First byte address past the end of the scratchpad
  localparam apbAddrT windowEnd = apbAddrT'(lineCount * LINE_BYTES);

  frontStateT state;
  frontStateT stateNext;

  // High in the SETUP cycle of a transfer
  logic       setup;

  // Setup seen while idle, so the request is taken on this edge
  logic       capture;

  // Address lies inside the configured window
  logic       inRange;

  // Registered error flag for the transfer in flight
  logic       errQ;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign setup   = psel && !penable;
  assign capture = (state == frontIdle) && setup;
  assign inRange = paddr < windowEnd;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  // Every transfer spends exactly one cycle in access and one in respond,
  // which gives the fixed single wait state
  always_comb begin
    stateNext = state;
    unique case (state)
      frontIdle: begin
        if (setup) begin
          stateNext = frontAccess;
        end
      end
      frontAccess: begin
        stateNext = frontRespond;
      end
      frontRespond: begin
        // The requester sees pready now and completes on this edge
        stateNext = frontIdle;
      end
      default: begin
        stateNext = frontIdle;
      end
    endcase
  end

  // Control registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= frontIdle;
      reqValid <= 1'b0;
      errQ     <= 1'b0;
    end else begin
      state <= stateNext;
      // The SRAM request lives for the first access cycle only
      // Out-of-window addresses never reach the array
      reqValid <= capture && inRange;
      if (capture) begin
        errQ <= !inRange;
      end
    end
  end

  // Request payload, held steady until the next SETUP
  always_ff @(posedge clk) begin
    if (capture) begin
      req.write   <= pwrite;
      req.wordSel <= paddr[WORD_OFFSET_W +: WORD_SEL_W];
      req.strb    <= pstrb;
      req.wdata   <= pwdata;
      lineIdx     <= paddr[LINE_OFFSET_W +: idxWidth];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  assign pready  = (state == frontRespond);
  assign pslverr = pready && errQ;

  // Only a good read returns the lane from the SRAM
  // Writes and errored reads give zero
  assign prdata = (pready && !errQ && !req.write) ? rdWord : '0;

  // The requester stays in ACCESS until completion, so pready only ever
  // meets a bus that still has psel and penable up
  apbReadyInAccess : assert property (
    @(posedge clk) disable iff (!arstN)
    pready |-> psel && penable
  ) else $error("pready outside an APB ACCESS phase");

  // A single transfer issues at most one SRAM request
  singleRequestPulse : assert property (
    @(posedge clk) disable iff (!arstN)
    reqValid |=> !reqValid
  ) else $error("reqValid held for two cycles");

endmodule

/* sram/sram1p1rw.sv */
// Single-port byte-writable SRAM

`timescale 1ns/100ps

module sram1p1rw #(
  parameter int lineCount = 256
) (
  input  logic                         clk,
  input  logic [$clog2(lineCount)-1:0] Adr,
  input  scratchPkg::lineDataT         CacheWriteData,
  input  logic                         WriteEnable,
  input  scratchPkg::lineStrbT         ByteWe,
  output scratchPkg::lineDataT         ReadData
);

  import scratchPkg::*;

  localparam int idxWidth = $clog2(lineCount);

  // The array itself, one entry per line
  lineDataT            storedData [lineCount];

  // Address sampled on the request edge
  logic [idxWidth-1:0] adrQ;

  //////////////////////////////////////////////////////////////////////
  // Write port and read address register
  //////////////////////////////////////////////////////////////////////

  // Both the write and the read address are taken on the same edge
  // Each byte lane is written only when its enable is set
  always_ff @(posedge clk) begin
    adrQ <= Adr;
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (WriteEnable && ByteWe[b]) begin
        storedData[Adr][8*b +: 8] <= CacheWriteData[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // The line at the registered address shows up in the cycle after
  // the request, so a read is valid one clock later
  // A write and a read of the same line on one edge return the new data
  assign ReadData = storedData[adrQ];

endmodule

/* common/scratchPkg.sv */
// Scratchpad shared definitions

package scratchPkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and line geometry
  //////////////////////////////////////////////////////////////////////

  // Width of the APB byte address
  localparam int APB_ADDR_W = 32;

  // Width of one APB data word
  localparam int APB_DATA_W = 32;

  // One strobe bit per byte of the APB word
  localparam int APB_STRB_W = APB_DATA_W / 8;

  // Each SRAM line holds this many APB words
  localparam int WORDS_PER_LINE = 4;

  // A full line is four words wide
  localparam int LINE_DATA_W = APB_DATA_W * WORDS_PER_LINE;

  // Number of bytes in a line, which is also the number of byte enables
  localparam int LINE_BYTES = LINE_DATA_W / 8;

  // Address bits that pick a byte inside a word
  localparam int WORD_OFFSET_W = $clog2(APB_STRB_W);

  // Address bits that pick a word inside a line
  localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

  // The line index starts right above this many address bits
  localparam int LINE_OFFSET_W = WORD_OFFSET_W + WORD_SEL_W;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [APB_ADDR_W-1:0]  apbAddrT;
  typedef logic [APB_DATA_W-1:0]  apbDataT;
  typedef logic [APB_STRB_W-1:0]  apbStrbT;
  typedef logic [LINE_DATA_W-1:0] lineDataT;
  typedef logic [LINE_BYTES-1:0]  lineStrbT;
  typedef logic [WORD_SEL_W-1:0]  wordSelT;

  // One word request handed from the APB front stage to the lane stage
  // The line index goes beside it because its width follows lineCount
  typedef struct packed {
    logic    write;
    wordSelT wordSel;
    apbStrbT strb;
    apbDataT wdata;
  } lineReqT;

  // Front stage walks idle, access, respond for every transfer
  typedef enum logic [1:0] {
    frontIdle,
    frontAccess,
    frontRespond
  } frontStateT;

endpackage
